/* verilog/game_defines.svh */
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// zombie lanes on the lawn
`define LANES 5

// zombies enter at the right edge
`define X_START 10'd799
// a live zombie here ends the game
`define END_OF_LAWN 10'd124

// pea hits needed per zombie
`define HITS_TO_KILL 5

// clock cycles per one-pixel step, 500000 on the board
`define MOVE_TICKS 4

// staggered entry thresholds
`define RELEASE_FAR 10'd600
`define RELEASE_NEAR 10'd700

// seed zone along the top of the screen
`define GREY_ZONE_BOTTOM 10'd159

// lane geometry
`define LANE0_TOP 10'd87
`define LANE_PITCH 10'd87
`define BODY_HEIGHT 10'd128
`define HALF_BODY_WIDTH 10'd8
`define HEAD_RADIUS 10'd21
`define OUTLINE_WIDTH 10'd2

// lawn checker cell
`define GRID_CELL 10'd160

`endif

/* verilog/colorPkg.sv */
package colorPkg;

	// 4:4:4 pixel, red in the top nibble
	typedef logic [11:0] rgb_t;

	typedef enum rgb_t
	{
		BLACK       = 12'b0000_0000_0000,
		GREY        = 12'b0000_1011_0100,
		GREEN       = 12'b0000_1111_0000,
		DARK_GREEN  = 12'b0011_1001_0010,
		ZOMBIE_SKIN = 12'b1010_1010_1011,
		ZOMBIE_EYE  = 12'b1111_1111_1111
	} palette_e;

	// head drawn in the skin color
	localparam palette_e ZOMBIE_HEAD = ZOMBIE_SKIN;

endpackage

/* verilog/gamePkg.sv */
package gamePkg;

	// screen coordinate, also used for the scan counters
	typedef logic [9:0] xPos_t;

	// lane number of a pea hit
	typedef logic [2:0] laneIdx_t;

	// hits taken by one zombie
	typedef logic [2:0] hitCount_t;

	// one-hot game state
	typedef enum logic [2:0]
	{
		PLAYING = 3'b001,
		WON     = 3'b010,
		LOST    = 3'b100
	} gameState_e;

endpackage

/* verilog/zombieLane.sv */
`timescale 1ns/1ps
`include "game_defines.svh"

module zombieLane (
	input  logic           clk,
	input  logic           rstN,
	input  logic           step,
	input  logic           hit,
	output gamePkg::xPos_t x,
	output logic           alive,
	output logic           killPulse
);
	import gamePkg::*;

	// hits taken so far
	hitCount_t hits;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			x         <= `X_START;
			hits      <= '0;
			alive     <= 1'b1;
			killPulse <= 1'b0;
		end
		else
		begin
			killPulse <= 1'b0;
			// march left, stop at the end of the lawn
			if (step && alive && (x > `END_OF_LAWN))
			begin
				x <= x - 10'd1;
			end
			// dead zombies ignore further peas
			if (hit && alive)
			begin
				hits <= hits + 3'd1;
				// fatal hit, drop alive and flag the kill
				if (hits == 3'(`HITS_TO_KILL - 1))
				begin
					alive     <= 1'b0;
					killPulse <= 1'b1;
				end
			end
		end
	end

	// zombie never walks past the end of the lawn
	xFloor: assert property (@(posedge clk) disable iff (!rstN)
		x >= `END_OF_LAWN);

endmodule

/* verilog/zombieWave.sv */
`timescale 1ns/1ps
`include "game_defines.svh"

module zombieWave #(
	parameter int MoveTicks = `MOVE_TICKS
) (
	input  logic              clk,
	input  logic              rstN,
	input  logic              running,
	input  logic              hitStrobe,
	input  gamePkg::laneIdx_t hitLane,
	output gamePkg::xPos_t    laneX [`LANES],
	output logic [`LANES-1:0] alive,
	output logic              killPulse,
	output logic              breach
);
	import gamePkg::*;

	localparam int CntW = $clog2(MoveTicks + 1);

	logic [CntW-1:0]   tickCount;
	logic              tick;
	logic [`LANES-1:0] released;
	logic [`LANES-1:0] step;
	logic [`LANES-1:0] hit;
	logic [`LANES-1:0] lanePulse;
	logic [`LANES-1:0] atEnd;

	// movement tick, only counts while the game runs
	assign tick = running && (tickCount == CntW'(MoveTicks - 1));

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			tickCount <= '0;
		end
		else if (running)
		begin
			tickCount <= tick ? '0 : tickCount + 1'b1;
		end
	end

	// staggered entry, judged on positions before the step
	// lane 1 leads
	assign released[1] = 1'b1;
	assign released[0] = laneX[1] <= `RELEASE_FAR;
	assign released[2] = laneX[0] <= `RELEASE_FAR;
	assign released[3] = laneX[0] <= `RELEASE_NEAR;
	assign released[4] = laneX[3] <= `RELEASE_NEAR;

	for (genvar i = 0; i < `LANES; i++)
	begin : gLane
		assign step[i] = tick && released[i];
		// hit decode, frozen game takes no hits
		assign hit[i] = hitStrobe && running && (hitLane == laneIdx_t'(i));
		assign atEnd[i] = laneX[i] == `END_OF_LAWN;

		zombieLane lane (
			.clk      (clk),
			.rstN     (rstN),
			.step     (step[i]),
			.hit      (hit[i]),
			.x        (laneX[i]),
			.alive    (alive[i]),
			.killPulse(lanePulse[i])
		);
	end

	// at most one lane dies per cycle
	assign killPulse = |lanePulse;
	// only a live zombie at the end loses the game
	assign breach = |(alive & atEnd);

	hitLaneRange: assert property (@(posedge clk) disable iff (!rstN)
		hitStrobe |-> (hitLane < `LANES));

endmodule

/* verilog/gameState.sv */
`timescale 1ns/1ps
`include "game_defines.svh"

module gameState (
	input  logic        clk,
	input  logic        rstN,
	input  logic        killPulse,
	input  logic        breach,
	output logic        running,
	output logic [15:0] zombiesKilled,
	output logic        won,
	output logic        lost
);
	import gamePkg::*;

	gameState_e state;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state         <= PLAYING;
			zombiesKilled <= '0;
		end
		else if (state == PLAYING)
		begin
			if (killPulse)
			begin
				zombiesKilled <= zombiesKilled + 16'd1;
			end
			// last kill wins at the same edge it is counted
			if (killPulse && (zombiesKilled == 16'(`LANES - 1)))
			begin
				state <= WON;
			end
			else if (breach)
			begin
				state <= LOST;
			end
		end
		// WON and LOST hold until reset
	end

	assign running = state == PLAYING;
	assign won     = state == WON;
	assign lost    = state == LOST;

endmodule

/* verilog/lawnRenderer.sv */
`timescale 1ns/1ps
`include "game_defines.svh"

module lawnRenderer (
	input  logic              clk,
	input  logic              rstN,
	input  logic              bright,
	input  gamePkg::xPos_t    hCount,
	input  gamePkg::xPos_t    vCount,
	input  gamePkg::xPos_t    laneX [`LANES],
	input  logic [`LANES-1:0] alive,
	output colorPkg::rgb_t    rgb
);
	import gamePkg::*;
	import colorPkg::*;

	// eye sits left of the head center
	localparam xPos_t EyeOffset = `HEAD_RADIUS / 2;

	logic [`LANES-1:0] eye;
	logic [`LANES-1:0] head;
	logic [`LANES-1:0] outline;
	logic [`LANES-1:0] body;
	xPos_t             gridRow;
	xPos_t             gridCol;
	palette_e          nextColor;

	for (genvar i = 0; i < `LANES; i++)
	begin : gLane
		xPos_t              top;
		logic signed [10:0] dx;
		logic signed [10:0] dy;
		logic [21:0]        dx2;
		logic [21:0]        dy2;
		logic               inBox;
		logic               inCore;

		assign top = xPos_t'(`LANE0_TOP + i * `LANE_PITCH);
		// head circle centered on the body top
		assign dx  = $signed({1'b0, hCount}) - $signed({1'b0, laneX[i]});
		assign dy  = $signed({1'b0, vCount}) - $signed({1'b0, top});
		assign dx2 = 22'(dx * dx);
		assign dy2 = 22'(dy * dy);
		assign head[i] = alive[i] && (dx2 + dy2 <= 22'(`HEAD_RADIUS * `HEAD_RADIUS));
		// 5x5 eye
		assign eye[i] = alive[i]
			&& (hCount >= laneX[i] - EyeOffset - 10'd2)
			&& (hCount <= laneX[i] - EyeOffset + 10'd2)
			&& (vCount >= top - 10'd6) && (vCount <= top - 10'd2);
		// full body box
		assign inBox = (vCount >= top) && (vCount <= top + `BODY_HEIGHT)
			&& (hCount >= laneX[i] - `HALF_BODY_WIDTH)
			&& (hCount <= laneX[i] + `HALF_BODY_WIDTH);
		// box minus the side and bottom rim
		assign inCore = (vCount >= top)
			&& (vCount <= top + `BODY_HEIGHT - `OUTLINE_WIDTH)
			&& (hCount >= laneX[i] - `HALF_BODY_WIDTH + `OUTLINE_WIDTH)
			&& (hCount <= laneX[i] + `HALF_BODY_WIDTH - `OUTLINE_WIDTH);
		assign outline[i] = alive[i] && inBox && !inCore;
		assign body[i]    = alive[i] && inCore;
	end

	// checker cell indices
	assign gridRow = vCount / `GRID_CELL;
	assign gridCol = hCount / `GRID_CELL;

	always_comb
	begin
		if (!bright)
			nextColor = BLACK;
		else if (|eye)
			nextColor = ZOMBIE_EYE;
		else if (|head)
			nextColor = ZOMBIE_HEAD;
		else if (|outline)
			nextColor = BLACK;
		else if (|body)
			nextColor = ZOMBIE_SKIN;
		else if (vCount <= `GREY_ZONE_BOTTOM)
			nextColor = GREY;
		// dark cell where row and column parity differ
		else if (gridRow[0] ^ gridCol[0])
			nextColor = DARK_GREEN;
		else
			nextColor = GREEN;
	end

	// one cycle behind the scan counters
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			rgb <= BLACK;
		else
			rgb <= nextColor;
	end

endmodule

/* verilog/lawnGameTop.sv */
`timescale 1ns/1ps
`include "game_defines.svh"

module lawnGameTop #(
	parameter int MoveTicks = `MOVE_TICKS
) (
	input  logic              clk,
	input  logic              rstN,
	input  logic              bright,
	input  gamePkg::xPos_t    hCount,
	input  gamePkg::xPos_t    vCount,
	input  logic              hitStrobe,
	input  gamePkg::laneIdx_t hitLane,
	output colorPkg::rgb_t    rgb,
	output logic [15:0]       zombiesKilled,
	output logic              won,
	output logic              lost
);
	import gamePkg::*;

	// lane positions shared by wave and renderer
	xPos_t             laneX [`LANES];
	logic [`LANES-1:0] alive;
	// wave and state handshake
	logic              running;
	logic              killPulse;
	logic              breach;

	zombieWave #(
		.MoveTicks(MoveTicks)
	) wave (
		.clk      (clk),
		.rstN     (rstN),
		.running  (running),
		.hitStrobe(hitStrobe),
		.hitLane  (hitLane),
		.laneX    (laneX),
		.alive    (alive),
		.killPulse(killPulse),
		.breach   (breach)
	);

	gameState state (
		.clk          (clk),
		.rstN         (rstN),
		.killPulse    (killPulse),
		.breach       (breach),
		.running      (running),
		.zombiesKilled(zombiesKilled),
		.won          (won),
		.lost         (lost)
	);

	// pixel color for the VGA scan
	lawnRenderer renderer (
		.clk   (clk),
		.rstN  (rstN),
		.bright(bright),
		.hCount(hCount),
		.vCount(vCount),
		.laneX (laneX),
		.alive (alive),
		.rgb   (rgb)
	);

endmodule

/* sim/lawnGameTb.sv */
`timescale 1ns/1ps
`include "game_defines.svh"

module lawnGameTb;
	import gamePkg::*;
	import colorPkg::*;

	localparam int MoveTicks = `MOVE_TICKS;
	localparam int XStart = `X_START;
	localparam int EndLawn = `END_OF_LAWN;
	localparam int HeadR = `HEAD_RADIUS;
	localparam int HalfW = `HALF_BODY_WIDTH;
	localparam int OutW = `OUTLINE_WIDTH;
	localparam int BodyH = `BODY_HEIGHT;
	// whole loss run plus margin from reset release
	localparam int Limit = 680 * MoveTicks + 500;

	logic        clk;
	logic        rstN;
	logic        bright;
	logic        hitStrobe;
	xPos_t       hCount;
	xPos_t       vCount;
	laneIdx_t    hitLane;
	rgb_t        rgb;
	logic [15:0] zombiesKilled;
	logic        won;
	logic        lost;

	// lane model state
	int                refX [`LANES];
	int                refCount;
	int                refTicks;
	logic              refLost;
	logic [`LANES-1:0] rel;
	logic              atEnd;
	// expected color of the pixel driven now and of the one in the pipeline
	logic              pixValid;
	logic              pendValid;
	rgb_t              pixExp;
	rgb_t              pendExp;
	int                checks;
	int                errors;
	int                testErrors;
	int                tests;
	int                watch = 0;
	int unsigned       seed;

	lawnGameTop #(.MoveTicks(MoveTicks)) UUT (
		.clk          (clk),
		.rstN         (rstN),
		.bright       (bright),
		.hCount       (hCount),
		.vCount       (vCount),
		.hitStrobe    (hitStrobe),
		.hitLane      (hitLane),
		.rgb          (rgb),
		.zombiesKilled(zombiesKilled),
		.won          (won),
		.lost         (lost)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
		end
	endtask

	// expected pixel by the priority rule with all lanes alive
	function automatic rgb_t refColor(input int h, input int v, input logic b);
		int   top;
		int   dx;
		int   dy;
		logic eye;
		logic head;
		logic outl;
		logic body;
		logic inBox;
		logic inCore;
		eye  = 1'b0;
		head = 1'b0;
		outl = 1'b0;
		body = 1'b0;
		for (int i = 0; i < `LANES; i++)
		begin
			top = `LANE0_TOP + i * `LANE_PITCH;
			dx  = h - refX[i];
			dy  = v - top;
			head |= (dx * dx + dy * dy) <= HeadR * HeadR;
			// 5x5 eye left of the head center
			eye |= (dx >= -(HeadR / 2) - 2) && (dx <= -(HeadR / 2) + 2)
				&& (dy >= -6) && (dy <= -2);
			inBox  = (dy >= 0) && (dy <= BodyH) && (dx >= -HalfW) && (dx <= HalfW);
			inCore = (dy >= 0) && (dy <= BodyH - OutW)
				&& (dx >= OutW - HalfW) && (dx <= HalfW - OutW);
			outl |= inBox && !inCore;
			body |= inCore;
		end
		if (!b)
			return BLACK;
		if (eye)
			return ZOMBIE_EYE;
		if (head)
			return ZOMBIE_HEAD;
		if (outl)
			return BLACK;
		if (body)
			return ZOMBIE_SKIN;
		if (v <= `GREY_ZONE_BOTTOM)
			return GREY;
		if (((v / `GRID_CELL) % 2) != ((h / `GRID_CELL) % 2))
			return DARK_GREEN;
		return GREEN;
	endfunction

	// lane positions per movement tick with release judged before the step
	always @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < `LANES; i++)
				refX[i] = XStart;
			refCount = 0;
			refTicks = 0;
			refLost  = 1'b0;
		end
		else if (!refLost)
		begin
			rel[1] = 1'b1;
			rel[0] = refX[1] <= `RELEASE_FAR;
			rel[2] = refX[0] <= `RELEASE_FAR;
			rel[3] = refX[0] <= `RELEASE_NEAR;
			rel[4] = refX[3] <= `RELEASE_NEAR;
			atEnd  = 1'b0;
			for (int i = 0; i < `LANES; i++)
				atEnd |= refX[i] == EndLawn;
			if (refCount == MoveTicks - 1)
			begin
				refCount = 0;
				refTicks++;
				for (int i = 0; i < `LANES; i++)
					if (rel[i] && refX[i] > EndLawn)
						refX[i]--;
			end
			else
				refCount++;
			// live zombie at the end means lost one edge later
			if (atEnd)
				refLost = 1'b1;
		end
	end

	// rgb one cycle after its pixel and lost on every cycle
	always @(posedge clk)
	begin
		#3;
		if (rstN)
		begin
			if (pendValid)
				check("rgb", rgb, pendExp);
			check("lost", lost, refLost);
		end
		pendValid = pixValid;
		pendExp   = pixExp;
	end

	always @(posedge clk)
	begin
		if (!rstN)
			watch <= 0;
		else
			watch <= watch + 1;
	end

	initial
	begin : watchdog
		while (watch < Limit)
			@(posedge clk);
		$display("Timeout: game did not finish within %0d cycles of reset", Limit);
		$display("test failed");
		$finish;
	end

	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic applyReset();
		rstN      = 1'b0;
		hitStrobe = 1'b0;
		bright    = 1'b0;
		pixValid  = 1'b0;
		repeat (3) nextCycle();
		rstN = 1'b1;
	endtask

	task automatic drivePixel(input int h, input int v, input logic b);
		hCount   = xPos_t'(h);
		vCount   = xPos_t'(v);
		bright   = b;
		pixExp   = refColor(h, v, b);
		pixValid = 1'b1;
		nextCycle();
	endtask

	task automatic flushPixels();
		pixValid = 1'b0;
		bright   = 1'b0;
		repeat (2) nextCycle();
	endtask

	task automatic sendHit(input int lane);
		hitStrobe = 1'b1;
		hitLane   = laneIdx_t'(lane);
		nextCycle();
		hitStrobe = 1'b0;
	endtask

	// body, eye, head, outline and background around one zombie
	task automatic scanZombie(input int i);
		int x;
		int top;
		x   = refX[i];
		top = `LANE0_TOP + i * `LANE_PITCH;
		drivePixel(x, top + 40, 1'b1);
		drivePixel(x - HeadR / 2, top - 4, 1'b1);
		drivePixel(x + 12, top - 12, 1'b1);
		drivePixel(x + HalfW, top + 60, 1'b1);
		drivePixel(x + 30, top + 60, 1'b1);
	endtask

	task automatic endTest(input string name);
		tests++;
		$display("[%0d] %s: %0d errors", tests, name, errors - testErrors);
		testErrors = errors;
	endtask

	initial
	begin
		int order [25];
		int j;
		int tmp;
		int cyc;
		rstN       = 1'b0;
		bright     = 1'b0;
		hitStrobe  = 1'b0;
		hitLane    = '0;
		hCount     = '0;
		vCount     = '0;
		pixValid   = 1'b0;
		pixExp     = BLACK;
		pendValid  = 1'b0;
		checks     = 0;
		errors     = 0;
		testErrors = 0;
		tests      = 0;
		seed       = 32'h095e34ae;
		void'($urandom(seed));

		applyReset();
		check("won", won, 0);
		check("lost", lost, 0);
		check("zombiesKilled", zombiesKilled, 0);
		repeat (120) drivePixel($urandom % 640, $urandom % 480, 1'b1);
		// blanking
		repeat (10) drivePixel($urandom % 640, $urandom % 480, 1'b0);
		flushPixels();
		endTest("reset state and pixel sweep");

		applyReset();
		repeat (4) sendHit(2);
		repeat (3) nextCycle();
		check("zombiesKilled", zombiesKilled, 0);
		sendHit(2);
		check("zombiesKilled", zombiesKilled, 0);
		nextCycle();
		check("zombiesKilled", zombiesKilled, 1);
		// dead lane takes no more hits
		repeat (3) sendHit(2);
		repeat (3) nextCycle();
		check("zombiesKilled", zombiesKilled, 1);
		check("won", won, 0);
		endTest("kill one zombie");

		applyReset();
		for (int i = 0; i < 25; i++)
			order[i] = i % `LANES;
		for (int i = 24; i > 0; i--)
		begin
			j        = $urandom % (i + 1);
			tmp      = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		foreach (order[i])
			sendHit(order[i]);
		check("zombiesKilled", zombiesKilled, 4);
		check("won", won, 0);
		nextCycle();
		check("won", won, 1);
		check("zombiesKilled", zombiesKilled, 5);
		// frozen after the win
		repeat (4) sendHit($urandom % `LANES);
		repeat (3) nextCycle();
		check("zombiesKilled", zombiesKilled, 5);
		check("won", won, 1);
		check("lost", lost, 0);
		endTest("win in random hit order");

		applyReset();
		while (refTicks < 320)
			nextCycle();
		for (int i = 0; i < `LANES; i++)
			scanZombie(i);
		flushPixels();
		endTest("zombie drawing after march");

		applyReset();
		cyc = 0;
		while (!lost)
		begin
			nextCycle();
			cyc++;
		end
		// lane 1 leads and LOST follows breach by one edge
		check("lost cycle", cyc, (XStart - EndLawn) * MoveTicks + 1);
		repeat (8) nextCycle();
		check("lost", lost, 1);
		check("won", won, 0);
		// frozen game ignores hits to a live lane
		repeat (`HITS_TO_KILL) sendHit(1);
		scanZombie(1);
		flushPixels();
		check("zombiesKilled", zombiesKilled, 0);
		endTest("loss at end of lawn");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+verilog
verilog/colorPkg.sv
verilog/gamePkg.sv
verilog/zombieLane.sv
verilog/zombieWave.sv
verilog/gameState.sv
verilog/lawnRenderer.sv
verilog/lawnGameTop.sv
sim/lawnGameTb.sv

/* Bender.yml */
package:
  name: lawn_game

export_include_dirs:
  - verilog

sources:
  - verilog/colorPkg.sv
  - verilog/gamePkg.sv
  - verilog/zombieLane.sv
  - verilog/zombieWave.sv
  - verilog/gameState.sv
  - verilog/lawnRenderer.sv
  - verilog/lawnGameTop.sv
  - target: simulation
    files:
      - sim/lawnGameTb.sv
